// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_dbg_monitor
FLIST     := build.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***
FAIL_MSG  := *** TEST FAILED ***

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
dbg_isa_pkg.sv
dbg_trace_pkg.sv
dbg_instr_classifier.sv
dbg_cause_tracker.sv
dbg_dpc_predictor.sv
dbg_monitor_ctrl.sv
dbg_monitor_top.sv
tb_dbg_monitor.sv

// File: dbg_cause_tracker.sv
// Expected debug cause register with fixed priority
// trigger > ebreak > haltreq > step
`default_nettype none

module dbg_cause_tracker
  import dbg_isa_pkg::*;
  import dbg_trace_pkg::*;
(
  input  wire               cov_assert_if,
  input  wire               rst_n_i,
  input  wire wb_trace_t    trace_i,
  input  wire instr_class_t class_i,
  input  wire dbg_state_t   dbg_i,
  input  wire               debug_req_i,
  input  wire               ebreakm_i,
  input  wire               trig_match_i,
  output dbg_cause_e        cause_o
);

  dbg_cause_e cause_q;
  logic       ebreak_hit;

  // Either ebreak form enters debug only with dcsr.ebreakm set
  assign ebreak_hit = ebreakm_i && (class_i.ebreak || class_i.cebreak);

  // --------------------------------------------------
  // Cause register
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cause_q <= NONE;
    end else if (!dbg_i.debug_mode) begin
      if (trig_match_i) begin
        cause_q <= TRIGGER;
      end else if (ebreak_hit) begin
        cause_q <= EBREAK;
      end else if (debug_req_i) begin
        cause_q <= HALTREQ;
      end else if (dbg_i.step && (cause_q inside {NONE, STEP})) begin
        // Step never overrides a pending higher cause
        cause_q <= STEP;
      end else if (trace_i.valid && !dbg_i.step) begin
        cause_q <= NONE;
      end
    end
  end

  assign cause_o = cause_q;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------

  // Every debug entry finds a pending expected cause
  a_cause_set_on_entry : assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    $rose(dbg_i.debug_mode) |-> (cause_q != NONE)
  ) else $error("debug mode entered with no expected debug cause");

endmodule

`default_nettype wire

// File: dbg_dpc_predictor.sv
// dpc prediction from the retirement trace and capture of
// the word aligned halt address on debug entry
`default_nettype none

module dbg_dpc_predictor
  import dbg_isa_pkg::*;
  import dbg_trace_pkg::*;
(
  input  wire                  cov_assert_if,
  input  wire                  rst_n_i,
  input  wire wb_trace_t       trace_i,
  input  wire dbg_state_t      dbg_i,
  input  wire dbg_cause_e      cause_i,
  input  wire                  capture_i,
  input  wire [XLEN-1:0]       halt_addr_i,
  output logic [XLEN-1:0]      exp_dpc_o,
  output logic [XLEN-1:0]      exp_halt_addr_o
);

  logic [XLEN-1:0] last_pc_q;
  logic [XLEN-1:0] last_pc_next_q;
  logic [XLEN-1:0] halt_addr_q;

  // --------------------------------------------------
  // Retirement history
  // --------------------------------------------------

  // Both addresses of the last retirement outside debug mode
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_pc_q      <= '0;
      last_pc_next_q <= '0;
    end else if (trace_i.valid && !dbg_i.debug_mode) begin
      last_pc_q      <= trace_i.pc;
      last_pc_next_q <= trace_i.pc_next;
    end
  end

  // ebreak and trigger halt on the instruction itself while
  // haltreq and step resume after it
  assign exp_dpc_o = (cause_i inside {EBREAK, TRIGGER}) ? last_pc_q : last_pc_next_q;

  // --------------------------------------------------
  // Halt address capture
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      halt_addr_q <= '0;
    end else if (capture_i) begin
      halt_addr_q <= {halt_addr_i[XLEN-1:2], 2'b00};
    end
  end

  assign exp_halt_addr_o = halt_addr_q;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------

  // A predicted dpc is always a legal halfword aligned pc
  a_dpc_halfword_aligned : assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    !exp_dpc_o[0]
  ) else $error("predicted dpc is not halfword aligned");

endmodule

`default_nettype wire

// File: dbg_instr_classifier.sv
// Writeback instruction classifier producing ebreak, c.ebreak,
// wfi and dret strobes for the retiring instruction
`default_nettype none

module dbg_instr_classifier
  import dbg_isa_pkg::*;
  import dbg_trace_pkg::*;
(
  input  wire wb_trace_t trace_i,
  output instr_class_t   class_o
);

  // Only clean retirements count, a faulted instruction never classifies
  logic retire_ok;

  assign retire_ok = trace_i.valid && !trace_i.err;

  // --------------------------------------------------
  // Opcode compare
  // --------------------------------------------------
  assign class_o.ebreak  = retire_ok && (trace_i.instr == EBREAK_OPCODE);
  assign class_o.cebreak = retire_ok && (trace_i.instr == CEBREAK_OPCODE);
  assign class_o.wfi     = retire_ok && (trace_i.instr == WFI_OPCODE);
  assign class_o.dret    = retire_ok && (trace_i.instr == DRET_OPCODE);

endmodule

`default_nettype wire

// File: dbg_isa_pkg.sv
// Instruction encodings, debug cause and monitor state enums,
// and the address width shared by the debug-entry monitor
`default_nettype none

package dbg_isa_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned XLEN = 32;

  // --------------------------------------------------
  // Instruction encodings checked at writeback
  // --------------------------------------------------
  localparam logic [XLEN-1:0] EBREAK_OPCODE  = 32'h0010_0073;
  // Compressed form sits in the low half, upper half zero
  localparam logic [XLEN-1:0] CEBREAK_OPCODE = 32'h0000_9002;
  localparam logic [XLEN-1:0] WFI_OPCODE     = 32'h1050_0073;
  localparam logic [XLEN-1:0] DRET_OPCODE    = 32'h7b20_0073;

  // --------------------------------------------------
  // Debug cause as reported in dcsr.cause
  // --------------------------------------------------
  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    TRIGGER = 3'd2,
    HALTREQ = 3'd3,
    STEP    = 3'd4
  } dbg_cause_e;

  // Debug episode tracking in the monitor control FSM
  typedef enum logic [1:0] {
    RUNNING  = 2'd0,
    SLEEPING = 2'd1,
    ENTERED  = 2'd2,
    IN_DEBUG = 2'd3
  } mon_state_e;

endpackage

`default_nettype wire

// File: dbg_monitor_ctrl.sv
// Debug episode FSM with WFI sleep tracking, trigger match,
// halt address capture strobe and first debug instruction checks
`default_nettype none

module dbg_monitor_ctrl
  import dbg_isa_pkg::*;
  import dbg_trace_pkg::*;
(
  input  wire               cov_assert_if,
  input  wire               rst_n_i,
  input  wire wb_trace_t    trace_i,
  input  wire instr_class_t class_i,
  input  wire dbg_state_t   dbg_i,
  input  wire               debug_req_i,
  input  wire               trig_en_i,
  input  wire [XLEN-1:0]    tdata2_i,
  input  wire dbg_cause_e   cause_i,
  input  wire [XLEN-1:0]    exp_dpc_i,
  input  wire [XLEN-1:0]    exp_halt_addr_i,
  output logic              trig_match_o,
  output logic              capture_o,
  output logic              in_wfi_o,
  output check_t            check_o
);

  mon_state_e state_q;
  mon_state_e state_d;
  logic       debug_mode_q;
  logic       dm_rise;
  logic       wfi_sleep;
  logic       first_ret;
  check_t     check_q;

  // --------------------------------------------------
  // Event detection
  // --------------------------------------------------
  assign trig_match_o = trig_en_i && trace_i.valid && (trace_i.pc == tdata2_i);

  assign dm_rise   = dbg_i.debug_mode && !debug_mode_q;
  assign capture_o = dm_rise;

  // wfi only sleeps outside debug, without step and with no request pending
  assign wfi_sleep = class_i.wfi && !dbg_i.debug_mode && !dbg_i.step && !debug_req_i;

  // First retirement after the halt address was captured
  assign first_ret = (state_q == ENTERED) && dbg_i.debug_mode && trace_i.valid;

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      RUNNING: begin
        if (dm_rise) begin
          state_d = ENTERED;
        end else if (wfi_sleep) begin
          state_d = SLEEPING;
        end
      end
      SLEEPING: begin
        if (dm_rise) begin
          state_d = ENTERED;
        end else if (debug_req_i) begin
          state_d = RUNNING;
        end
      end
      ENTERED: begin
        if (!dbg_i.debug_mode) begin
          state_d = RUNNING;
        end else if (first_ret) begin
          state_d = IN_DEBUG;
        end
      end
      IN_DEBUG: begin
        if (!dbg_i.debug_mode) begin
          state_d = RUNNING;
        end
      end
      default: state_d = RUNNING;
    endcase
  end

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= RUNNING;
      debug_mode_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      debug_mode_q <= dbg_i.debug_mode;
    end
  end

  assign in_wfi_o = (state_q == SLEEPING);

  // --------------------------------------------------
  // First instruction checks, one cycle after retirement
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      check_q <= '0;
    end else begin
      check_q.first_ins <= first_ret;
      check_q.err_cause <= first_ret && (dbg_i.cause != cause_i);
      check_q.err_dpc   <= first_ret && (dbg_i.dpc != exp_dpc_i);
      check_q.err_pc    <= first_ret && (trace_i.pc != exp_halt_addr_i);
    end
  end

  assign check_o = check_q;

  // --------------------------------------------------
  // Assertions
  // --------------------------------------------------

  // dret leaves debug mode right after it retires
  a_dret_exits_debug : assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    dbg_i.debug_mode && class_i.dret |=> !dbg_i.debug_mode
  ) else $error("dret in debug mode did not leave debug mode");

endmodule

`default_nettype wire

// File: dbg_monitor_top.sv
// Debug-entry monitor top level, connecting classifier,
// cause tracker, dpc predictor and control FSM
`default_nettype none

module dbg_monitor_top
  import dbg_isa_pkg::*;
  import dbg_trace_pkg::*;
(
  input  wire               cov_assert_if,
  input  wire               rst_n_i,
  input  wire wb_trace_t    trace_i,
  input  wire dbg_state_t   dbg_i,
  input  wire               debug_req_i,
  input  wire               ebreakm_i,
  input  wire               trig_en_i,
  input  wire [XLEN-1:0]    tdata2_i,
  input  wire [XLEN-1:0]    halt_addr_i,
  output check_t            check_o,
  output dbg_cause_e        exp_cause_o,
  output logic              in_wfi_o
);

  instr_class_t    iclass;
  logic            trig_match;
  logic            capture;
  logic [XLEN-1:0] exp_dpc;
  logic [XLEN-1:0] exp_halt_addr;

  dbg_instr_classifier u_classifier (
    .trace_i (trace_i),
    .class_o (iclass)
  );

  dbg_cause_tracker u_cause_tracker (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .trace_i       (trace_i),
    .class_i       (iclass),
    .dbg_i         (dbg_i),
    .debug_req_i   (debug_req_i),
    .ebreakm_i     (ebreakm_i),
    .trig_match_i  (trig_match),
    .cause_o       (exp_cause_o)
  );

  dbg_dpc_predictor u_dpc_predictor (
    .cov_assert_if   (cov_assert_if),
    .rst_n_i         (rst_n_i),
    .trace_i         (trace_i),
    .dbg_i           (dbg_i),
    .cause_i         (exp_cause_o),
    .capture_i       (capture),
    .halt_addr_i     (halt_addr_i),
    .exp_dpc_o       (exp_dpc),
    .exp_halt_addr_o (exp_halt_addr)
  );

  dbg_monitor_ctrl u_ctrl (
    .cov_assert_if   (cov_assert_if),
    .rst_n_i         (rst_n_i),
    .trace_i         (trace_i),
    .class_i         (iclass),
    .dbg_i           (dbg_i),
    .debug_req_i     (debug_req_i),
    .trig_en_i       (trig_en_i),
    .tdata2_i        (tdata2_i),
    .cause_i         (exp_cause_o),
    .exp_dpc_i       (exp_dpc),
    .exp_halt_addr_i (exp_halt_addr),
    .trig_match_o    (trig_match),
    .capture_o       (capture),
    .in_wfi_o        (in_wfi_o),
    .check_o         (check_o)
  );

endmodule

`default_nettype wire

// File: dbg_trace_pkg.sv
// Packed structs for the writeback trace, the core debug state,
// the instruction class strobes and the check results
`default_nettype none

package dbg_trace_pkg;

  import dbg_isa_pkg::*;

  // --------------------------------------------------
  // Writeback retirement trace
  // --------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic            err;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    // Address of the next instruction after this one retires
    logic [XLEN-1:0] pc_next;
  } wb_trace_t;

  // Debug CSR view of the core
  typedef struct packed {
    logic            debug_mode;
    dbg_cause_e      cause;
    logic            step;
    logic [XLEN-1:0] dpc;
  } dbg_state_t;

  // --------------------------------------------------
  // Derived strobes and results
  // --------------------------------------------------
  typedef struct packed {
    logic ebreak;
    logic cebreak;
    logic wfi;
    logic dret;
  } instr_class_t;

  typedef struct packed {
    logic first_ins;
    logic err_cause;
    logic err_dpc;
    logic err_pc;
  } check_t;

endpackage

`default_nettype wire

// File: tb_dbg_monitor.sv
// Testbench for the debug-entry monitor with a behavioral core model,
// reference cause and dpc functions and a per-cycle compare process
`default_nettype none

module tb_dbg_monitor
  import dbg_isa_pkg::*;
  import dbg_trace_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int              WAIT_LIMIT = 40;
  localparam logic [XLEN-1:0] NOP_OPCODE = 32'h0000_0013;
  localparam logic [XLEN-1:0] TRIG_ADDR  = 32'h0000_1010;
  // Unaligned on purpose so the capture has to drop the low bits
  localparam logic [XLEN-1:0] HALT_ADDR  = 32'h0000_0802;

  logic            cov_assert_if;
  logic            rst_n_i;
  wb_trace_t       trace;
  dbg_state_t      dbg;
  logic            debug_req;
  logic            ebreakm;
  logic            trig_en;
  logic [XLEN-1:0] tdata2;
  logic [XLEN-1:0] halt_addr;
  check_t          check;
  dbg_cause_e      exp_cause;
  logic            in_wfi;

  // Reference model state
  dbg_cause_e      model_cause;
  logic [XLEN-1:0] model_pc;
  logic [XLEN-1:0] model_pc_next;
  check_t          exp_check;
  int              exp_pulses;
  int              first_seen;
  integer          seed;

  dbg_monitor_top uut (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .trace_i       (trace),
    .dbg_i         (dbg),
    .debug_req_i   (debug_req),
    .ebreakm_i     (ebreakm),
    .trig_en_i     (trig_en),
    .tdata2_i      (tdata2),
    .halt_addr_i   (halt_addr),
    .check_o       (check),
    .exp_cause_o   (exp_cause),
    .in_wfi_o      (in_wfi)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #4 cov_assert_if = ~cov_assert_if;
  end

  // --------------------------------------------------
  // Reference functions
  // --------------------------------------------------
  function automatic dbg_cause_e next_cause(input dbg_cause_e cur, input wb_trace_t tr,
                                            input dbg_state_t ds, input logic req,
                                            input logic ebm, input logic ten,
                                            input logic [XLEN-1:0] td2);
    logic trig;
    logic brk;
    trig = ten && tr.valid && (tr.pc == td2);
    brk  = ebm && tr.valid && !tr.err &&
           ((tr.instr == EBREAK_OPCODE) || (tr.instr == CEBREAK_OPCODE));
    if (ds.debug_mode) return cur;
    if (trig) return TRIGGER;
    if (brk) return EBREAK;
    if (req) return HALTREQ;
    if (ds.step && ((cur == NONE) || (cur == STEP))) return STEP;
    if (tr.valid && !ds.step) return NONE;
    return cur;
  endfunction

  // ebreak and trigger halt on the instruction and the other causes after it
  function automatic logic [XLEN-1:0] saved_dpc(input dbg_cause_e c, input logic [XLEN-1:0] pc,
                                                input logic [XLEN-1:0] pc_next);
    if ((c == EBREAK) || (c == TRIGGER)) return pc;
    return pc_next;
  endfunction

  always @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      model_cause   <= NONE;
      model_pc      <= '0;
      model_pc_next <= '0;
    end else begin
      model_cause <= next_cause(model_cause, trace, dbg, debug_req, ebreakm, trig_en, tdata2);
      if (trace.valid && !dbg.debug_mode) begin
        model_pc      <= trace.pc;
        model_pc_next <= trace.pc_next;
      end
    end
  end

  // --------------------------------------------------
  // Error reporting and compare process
  // --------------------------------------------------
  task automatic abort_run(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
    $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    abort_run("value mismatch");
  endtask

  always @(negedge cov_assert_if) begin
    if (rst_n_i) begin
      assert (exp_cause == model_cause)
        else report_mismatch("exp_cause_o", 32'(exp_cause), 32'(model_cause));
      if (check.first_ins) begin
        assert (first_seen < exp_pulses) else abort_run("first_ins pulse without debug entry");
        assert (check == exp_check) else report_mismatch("check_o", 32'(check), 32'(exp_check));
        first_seen++;
      end else begin
        assert (check == '0) else report_mismatch("check_o", 32'(check), 32'h0);
      end
    end
  end

  // --------------------------------------------------
  // Core model
  // --------------------------------------------------
  task automatic next_cycle();
    @(posedge cov_assert_if);
    #1;
  endtask

  task automatic retire(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] instr);
    trace.valid   = 1'b1;
    trace.err     = 1'b0;
    trace.pc      = pc;
    trace.instr   = instr;
    trace.pc_next = pc + ((instr == CEBREAK_OPCODE) ? 32'h2 : 32'h4);
    next_cycle();
    trace.valid = 1'b0;
  endtask

  task automatic expect_cause(input dbg_cause_e c);
    assert (exp_cause == c) else report_mismatch("exp_cause_o", 32'(exp_cause), 32'(c));
  endtask

  task automatic check_reference_dpc(input logic [XLEN-1:0] val);
    logic [XLEN-1:0] dpc;
    dpc = saved_dpc(model_cause, model_pc, model_pc_next);
    assert (dpc == val) else report_mismatch("reference dpc", dpc, val);
  endtask

  task automatic wait_wfi_level(input logic level);
    int waited;
    waited = 0;
    while (in_wfi !== level) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("in_wfi_o did not reach the expected level");
    end
  endtask

  // Halt, retire the first debug instruction, wait for the check, then dret
  task automatic enter_and_check(input logic bad_cause, input logic bad_dpc,
                                 input logic bad_pc);
    int              waited;
    int              start;
    logic [XLEN-1:0] halt_pc;
    start              = first_seen;
    exp_check.first_ins = 1'b1;
    exp_check.err_cause = bad_cause;
    exp_check.err_dpc   = bad_dpc;
    exp_check.err_pc    = bad_pc;
    exp_pulses++;
    dbg.debug_mode = 1'b1;
    dbg.cause      = bad_cause ? ((model_cause == STEP) ? EBREAK : STEP) : model_cause;
    dbg.dpc        = saved_dpc(model_cause, model_pc, model_pc_next) ^ (bad_dpc ? 32'h4 : 32'h0);
    debug_req      = 1'b0;
    next_cycle();
    halt_pc = {halt_addr[XLEN-1:2], 2'b00} + (bad_pc ? 32'h10 : 32'h0);
    retire(halt_pc, NOP_OPCODE);
    waited = 0;
    while (first_seen == start) begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT) abort_run("no first_ins pulse after debug entry");
    end
    retire(halt_pc + 32'h4, DRET_OPCODE);
    dbg.debug_mode = 1'b0;
    next_cycle();
  endtask

  task automatic random_traffic(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = $random(seed);
      trace.valid = r[0] | r[1];
      trace.err   = r[2] & r[3];
      // Sixteen word addresses including the trigger address
      trace.pc    = 32'h0000_1000 + {26'd0, r[7:4], 2'b00};
      case (r[10:8])
        3'd0:    trace.instr = EBREAK_OPCODE;
        3'd1:    trace.instr = CEBREAK_OPCODE;
        3'd2:    trace.instr = WFI_OPCODE;
        default: trace.instr = NOP_OPCODE;
      endcase
      trace.pc_next = trace.pc + 32'h4;
      ebreakm       = r[11];
      trig_en       = r[12];
      debug_req     = (r[15:13] == 3'd0);
      dbg.step      = (r[18:16] == 3'd0);
      next_cycle();
    end
    trace.valid = 1'b0;
    debug_req   = 1'b0;
    trig_en     = 1'b0;
    dbg.step    = 1'b0;
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    seed       = 32'h059d_ee3b;
    rst_n_i    = 1'b0;
    trace      = '0;
    dbg        = '0;
    debug_req  = 1'b0;
    ebreakm    = 1'b0;
    trig_en    = 1'b0;
    tdata2     = TRIG_ADDR;
    halt_addr  = HALT_ADDR;
    exp_check  = '0;
    exp_pulses = 0;
    first_seen = 0;
    repeat (16) @(posedge cov_assert_if);
    #1;
    rst_n_i = 1'b1;
    next_cycle();
    assert (in_wfi == 1'b0) else report_mismatch("in_wfi_o", 32'(in_wfi), 32'h0);
    assert (check == '0) else report_mismatch("check_o", 32'(check), 32'h0);
    expect_cause(NONE);

    ebreakm = 1'b1;
    retire(32'h0000_0100, EBREAK_OPCODE);
    expect_cause(EBREAK);
    check_reference_dpc(32'h0000_0100);
    enter_and_check(1'b0, 1'b0, 1'b0);

    // Trigger outranks a simultaneous haltreq
    trig_en   = 1'b1;
    debug_req = 1'b1;
    retire(TRIG_ADDR, NOP_OPCODE);
    expect_cause(TRIGGER);
    check_reference_dpc(TRIG_ADDR);
    enter_and_check(1'b0, 1'b0, 1'b0);
    trig_en = 1'b0;

    debug_req = 1'b1;
    retire(32'h0000_0200, NOP_OPCODE);
    expect_cause(HALTREQ);
    check_reference_dpc(32'h0000_0204);
    enter_and_check(1'b0, 1'b0, 1'b0);

    // Sleep in wfi until a debug request wakes the core
    retire(32'h0000_0300, WFI_OPCODE);
    wait_wfi_level(1'b1);
    repeat (3) next_cycle();
    assert (in_wfi == 1'b1) else report_mismatch("in_wfi_o", 32'(in_wfi), 32'h1);
    debug_req = 1'b1;
    next_cycle();
    wait_wfi_level(1'b0);
    expect_cause(HALTREQ);
    check_reference_dpc(32'h0000_0304);
    enter_and_check(1'b0, 1'b0, 1'b0);

    // One injected core fault per entry
    for (int i = 0; i < 3; i++) begin
      debug_req = 1'b1;
      retire(32'h0000_0400 + 32'(i * 16), NOP_OPCODE);
      enter_and_check(i == 0, i == 1, i == 2);
    end

    random_traffic(300);
    repeat (2) next_cycle();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
